// File: logic/gfx_pkg.sv
package gfx_pkg;

  // video timing in pixel clocks and lines
  localparam int H_VISIBLE = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE = 3;
  localparam int H_BACK_PORCH = 3;
  localparam int H_WHOLE_LINE = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

  localparam int V_VISIBLE = 8;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE = 2;
  localparam int V_BACK_PORCH = 1;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

  localparam int PIXEL_BITS = 12;
  localparam int COLOR_BITS = 4;

  // buffer address is y * 16 + x
  localparam int FB_X_BITS = 4;
  localparam int FB_Y_BITS = 3;
  localparam int FB_ADDR_BITS = FB_Y_BITS + FB_X_BITS;
  localparam logic [FB_X_BITS-1:0] FB_X_LAST = FB_X_BITS'(H_VISIBLE - 1);
  localparam logic [FB_Y_BITS-1:0] FB_Y_LAST = FB_Y_BITS'(V_VISIBLE - 1);

  // scan counter widths and the positions the scanout compares against
  localparam int H_CNT_BITS = $clog2(H_WHOLE_LINE);
  localparam int V_CNT_BITS = $clog2(V_WHOLE_FRAME);
  localparam logic [H_CNT_BITS-1:0] H_VIS_END = H_CNT_BITS'(H_VISIBLE);
  localparam logic [H_CNT_BITS-1:0] H_SYNC_BEGIN = H_CNT_BITS'(H_VISIBLE + H_FRONT_PORCH);
  localparam logic [H_CNT_BITS-1:0] H_SYNC_END = H_SYNC_BEGIN + H_CNT_BITS'(H_SYNC_PULSE);
  localparam logic [H_CNT_BITS-1:0] H_LAST = H_CNT_BITS'(H_WHOLE_LINE - 1);
  localparam logic [V_CNT_BITS-1:0] V_VIS_END = V_CNT_BITS'(V_VISIBLE);
  localparam logic [V_CNT_BITS-1:0] V_SYNC_BEGIN = V_CNT_BITS'(V_VISIBLE + V_FRONT_PORCH);
  localparam logic [V_CNT_BITS-1:0] V_SYNC_END = V_SYNC_BEGIN + V_CNT_BITS'(V_SYNC_PULSE);
  localparam logic [V_CNT_BITS-1:0] V_LAST = V_CNT_BITS'(V_WHOLE_FRAME - 1);

  localparam int AXIL_ADDR_BITS = 4;
  localparam int AXIL_DATA_BITS = 32;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_CTRL = 4'h0;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_PATTERN = 4'h4;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_STATUS = 4'h8;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // mode 3 is decoded as solid
  localparam logic [1:0] MODE_SOLID = 2'd0;
  localparam logic [1:0] MODE_GRADIENT = 2'd1;
  localparam logic [1:0] MODE_CHECKER = 2'd2;

  typedef struct packed {
    logic [COLOR_BITS-1:0] red;
    logic [COLOR_BITS-1:0] grn;
    logic [COLOR_BITS-1:0] blu;
  } rgb_t;

  // raw is the stored word, rgb is the per-channel view
  typedef union packed {
    logic [PIXEL_BITS-1:0] raw;
    rgb_t                  rgb;
  } pixel_u;

  typedef struct packed {
    logic [FB_X_BITS-1:0] x;
    logic [FB_Y_BITS-1:0] y;
    pixel_u               color;
    logic                 last;
  } gfx_pixel_t;

  typedef struct packed {
    rgb_t color;
    logic hsync;
    logic vsync;
    logic de;
  } vga_out_t;

  typedef struct packed {
    logic       run;
    logic [1:0] mode;
    pixel_u     base;
  } gfx_cfg_t;

  typedef struct packed {
    logic                        awvalid;
    logic [AXIL_ADDR_BITS-1:0]   awaddr;
    logic                        wvalid;
    logic [AXIL_DATA_BITS-1:0]   wdata;
    logic [AXIL_DATA_BITS/8-1:0] wstrb;
    logic                        bready;
    logic                        arvalid;
    logic [AXIL_ADDR_BITS-1:0]   araddr;
    logic                        rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
  } axil_rsp_t;

endpackage

// File: logic/gfx_regs.sv
module gfx_regs (
  input  logic               clk,
  input  logic               reset,
  input  gfx_pkg::axil_req_t axil_req,
  output gfx_pkg::axil_rsp_t axil_rsp,
  input  logic               swap,
  input  logic               front,
  output gfx_pkg::gfx_cfg_t  cfg
);

  logic                               wr_fire;
  logic                               rd_fire;
  logic                               bvalid;
  logic [1:0]                         bresp;
  logic                               rvalid;
  logic [gfx_pkg::AXIL_DATA_BITS-1:0] rdata;
  logic [1:0]                         rresp;
  logic [gfx_pkg::AXIL_DATA_BITS-1:0] rd_word;
  logic                               rd_err;
  logic [15:0]                        swap_cnt;

  // address and data must arrive together, and only one write is in flight
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_fire = axil_req.arvalid && !rvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      cfg    <= '0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
      bresp  <= gfx_pkg::RESP_SLVERR;
      case (axil_req.awaddr)
        gfx_pkg::REG_CTRL: begin
          bresp <= gfx_pkg::RESP_OKAY;
          if (axil_req.wstrb[0]) begin
            cfg.run <= axil_req.wdata[0];
          end
        end
        gfx_pkg::REG_PATTERN: begin
          bresp <= gfx_pkg::RESP_OKAY;
          if (axil_req.wstrb[0]) begin
            cfg.mode <= axil_req.wdata[1:0];
          end
          // the base colour straddles byte lanes 2 and 3
          if (axil_req.wstrb[2]) begin
            cfg.base.raw[7:0] <= axil_req.wdata[23:16];
          end
          if (axil_req.wstrb[3]) begin
            cfg.base.raw[11:8] <= axil_req.wdata[27:24];
          end
        end
        default: begin
        end
      endcase
    end else if (bvalid && axil_req.bready) begin
      bvalid <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      gfx_pkg::REG_CTRL:    rd_word[0] = cfg.run;
      gfx_pkg::REG_PATTERN: rd_word = {4'b0, cfg.base.raw, 14'b0, cfg.mode};
      gfx_pkg::REG_STATUS:  rd_word = {swap_cnt, 15'b0, front};
      default:              rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
      rdata  <= rd_word;
      rresp  <= rd_err ? gfx_pkg::RESP_SLVERR : gfx_pkg::RESP_OKAY;
    end else if (rvalid && axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // swap count wraps at 16 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      swap_cnt <= '0;
    end else if (swap) begin
      swap_cnt <= swap_cnt + 16'd1;
    end
  end

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = !rvalid;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

endmodule

// File: logic/gfx_pattern.sv
module gfx_pattern (
  input  logic                clk,
  input  logic                reset,
  input  gfx_pkg::gfx_cfg_t   cfg,
  input  logic                swap,
  output gfx_pkg::gfx_pixel_t pix,
  output logic                pix_valid,
  input  logic                pix_ready
);

  logic                          busy;
  logic                          wait_swap;
  logic [1:0]                    mode_q;
  gfx_pkg::pixel_u               base_q;
  logic [gfx_pkg::FB_X_BITS-1:0] x_q;
  logic [gfx_pkg::FB_Y_BITS-1:0] y_q;
  gfx_pkg::pixel_u               color;
  logic                          start;

  assign start = !busy && !wait_swap && cfg.run;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      wait_swap <= 1'b0;
      x_q       <= '0;
      y_q       <= '0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (busy && pix_ready) begin
      if (pix.last) begin
        // the frame is complete, hold off until the buffers have swapped
        busy      <= 1'b0;
        wait_swap <= 1'b1;
        x_q       <= '0;
        y_q       <= '0;
      end else if (x_q == gfx_pkg::FB_X_LAST) begin
        x_q <= '0;
        y_q <= y_q + 1'b1;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end else if (wait_swap && swap) begin
      wait_swap <= 1'b0;
    end
  end

  // settings are sampled once per frame so a frame is never mixed
  always_ff @(posedge clk) begin
    if (start) begin
      mode_q <= cfg.mode;
      base_q <= cfg.base;
    end
  end

  always_comb begin
    color = base_q;
    case (mode_q)
      gfx_pkg::MODE_GRADIENT: begin
        color.rgb.red = gfx_pkg::COLOR_BITS'(x_q);
        color.rgb.grn = gfx_pkg::COLOR_BITS'(y_q);
      end
      gfx_pkg::MODE_CHECKER: begin
        if (x_q[0] != y_q[0]) begin
          color.rgb.red = ~base_q.rgb.red;
          color.rgb.grn = ~base_q.rgb.grn;
          color.rgb.blu = ~base_q.rgb.blu;
        end
      end
      default: begin
      end
    endcase
  end

  assign pix_valid = busy;
  assign pix.x     = x_q;
  assign pix.y     = y_q;
  assign pix.color = color;
  assign pix.last  = (x_q == gfx_pkg::FB_X_LAST) && (y_q == gfx_pkg::FB_Y_LAST);

endmodule

// File: logic/fb_dbuf.sv
module fb_dbuf (
  input  logic                             clk,
  input  logic                             reset,
  input  gfx_pkg::gfx_pixel_t              pix,
  input  logic                             pix_valid,
  output logic                             pix_ready,
  input  logic                             disp_en,
  input  logic                             frame_end,
  input  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  output gfx_pkg::pixel_u                  rd_data,
  output logic                             swap,
  output logic                             front
);

  // one 128-word array per buffer, selected by the front index
  gfx_pkg::pixel_u mem [2][2**gfx_pkg::FB_ADDR_BITS];

  logic                             back_full;
  logic                             wr_en;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] wr_addr;

  assign pix_ready = !back_full;
  assign wr_en     = pix_valid && pix_ready;
  assign wr_addr   = {pix.y, pix.x};

  // before the display is on there is no frame end to wait for,
  // so the first complete frame goes to the front at once
  assign swap = back_full && (frame_end || !disp_en);

  always_ff @(posedge clk) begin
    if (reset) begin
      front     <= 1'b0;
      back_full <= 1'b0;
    end else if (swap) begin
      front     <= !front;
      back_full <= 1'b0;
    end else if (wr_en && pix.last) begin
      back_full <= 1'b1;
    end
  end

  // the generator always fills the buffer that is not on screen
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[!front][wr_addr] <= pix.color;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[front][rd_addr];
  end

endmodule

// File: logic/vga_scan.sv
module vga_scan (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             disp_en,
  output logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr,
  input  gfx_pkg::pixel_u                  rd_data,
  output logic                             frame_end,
  output gfx_pkg::vga_out_t                vga
);

  logic [gfx_pkg::H_CNT_BITS-1:0] h_cnt;
  logic [gfx_pkg::V_CNT_BITS-1:0] v_cnt;
  logic                           visible;
  logic                           hsync_q;
  logic                           vsync_q;
  logic                           de_q;

  assign visible = (h_cnt < gfx_pkg::H_VIS_END) && (v_cnt < gfx_pkg::V_VIS_END);

  // the low counter bits index the picture directly
  assign rd_addr = {v_cnt[gfx_pkg::FB_Y_BITS-1:0], h_cnt[gfx_pkg::FB_X_BITS-1:0]};

  // high on the cycle the scan sits on the last visible pixel
  assign frame_end = disp_en && visible &&
                     (rd_addr == {gfx_pkg::FB_Y_LAST, gfx_pkg::FB_X_LAST});

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (disp_en) begin
      if (h_cnt == gfx_pkg::H_LAST) begin
        h_cnt <= '0;
        if (v_cnt == gfx_pkg::V_LAST) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // sync and de are delayed one stage to line up with the memory read
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      de_q    <= 1'b0;
    end else begin
      hsync_q <= disp_en && (h_cnt >= gfx_pkg::H_SYNC_BEGIN) &&
                 (h_cnt < gfx_pkg::H_SYNC_END);
      vsync_q <= disp_en && (v_cnt >= gfx_pkg::V_SYNC_BEGIN) &&
                 (v_cnt < gfx_pkg::V_SYNC_END);
      de_q    <= disp_en && visible;
    end
  end

  // blanking is forced black
  assign vga.color = de_q ? rd_data.rgb : '0;
  assign vga.hsync = hsync_q;
  assign vga.vsync = vsync_q;
  assign vga.de    = de_q;

endmodule

// File: logic/gfx_demo_dbuf.sv
module gfx_demo_dbuf (
  input  logic               clk,
  input  logic               reset,
  input  gfx_pkg::axil_req_t axil_req,
  output gfx_pkg::axil_rsp_t axil_rsp,
  output gfx_pkg::vga_out_t  vga
);

  gfx_pkg::gfx_cfg_t                cfg;
  gfx_pkg::gfx_pixel_t              pix;
  logic                             pix_valid;
  logic                             pix_ready;
  logic                             swap;
  logic                             front;
  logic                             frame_end;
  logic [gfx_pkg::FB_ADDR_BITS-1:0] rd_addr;
  gfx_pkg::pixel_u                  rd_data;
  logic                             disp_en;

  // the screen stays dark until a whole frame has been rendered once
  always_ff @(posedge clk) begin
    if (reset) begin
      disp_en <= 1'b0;
    end else if (swap) begin
      disp_en <= 1'b1;
    end
  end

  gfx_regs regs_inst (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .swap     (swap),
    .front    (front),
    .cfg      (cfg)
  );

  gfx_pattern pattern_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .swap      (swap),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready)
  );

  fb_dbuf fb_inst (
    .clk       (clk),
    .reset     (reset),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .disp_en   (disp_en),
    .frame_end (frame_end),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .swap      (swap),
    .front     (front)
  );

  vga_scan scan_inst (
    .clk       (clk),
    .reset     (reset),
    .disp_en   (disp_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .frame_end (frame_end),
    .vga       (vga)
  );

endmodule

// File: verification/gfx_demo_tb.sv
module gfx_demo_tb;

  logic               clk;
  logic               reset;
  gfx_pkg::axil_req_t req;
  gfx_pkg::axil_rsp_t rsp;
  gfx_pkg::vga_out_t  vga;

  int            err_cnt;
  int            chk_cnt;
  int            seed;
  int            frames_seen;
  int            frames_checked;
  int            skip_frames;
  logic [1:0]    exp_mode;
  gfx_pkg::rgb_t exp_base;
  logic [31:0]   pat_model;

  // monitor state
  logic          armed;
  logic          vsync_prev;
  int            pix_idx;
  int            de_run;
  int            de_lines;

  gfx_demo_dbuf dut (
    .clk      (clk),
    .reset    (reset),
    .axil_req (req),
    .axil_rsp (rsp),
    .vga      (vga)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_rgb(input string name, input gfx_pkg::rgb_t got,
                           input gfx_pkg::rgb_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_vga(input string name, input gfx_pkg::vga_out_t got,
                           input gfx_pkg::vga_out_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name,
                            input logic [gfx_pkg::AXIL_DATA_BITS-1:0] got,
                            input logic [gfx_pkg::AXIL_DATA_BITS-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // colour of pixel (x,y) for a given mode and base colour
  function automatic gfx_pkg::rgb_t expected_pixel(input logic [1:0] mode,
                                                   input gfx_pkg::rgb_t base,
                                                   input logic [3:0] x, input logic [2:0] y);
    gfx_pkg::rgb_t c;
    c = base;
    if (mode == gfx_pkg::MODE_GRADIENT) begin
      c.red = x;
      c.grn = {1'b0, y};
    end else if (mode == gfx_pkg::MODE_CHECKER && x[0] != y[0]) begin
      c = ~base;
    end
    return c;
  endfunction

  // only mode bits 1:0 and base bits 27:16 exist in the pattern register
  function automatic logic [31:0] merge_strobes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res & 32'h0fff_0003;
  endfunction

  function automatic logic sync_level(input bit use_v);
    return use_v ? vga.vsync : vga.hsync;
  endfunction

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    int n;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.wstrb   <= strb;
    req.bready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!(rsp.awready && rsp.wready) && n < 64) begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!rsp.bvalid && n < 64) begin
      @(negedge clk);
      n++;
    end
    if (n >= 64) begin
      err_cnt++;
      $display("timeout: the write to address %h got no response", addr);
    end else begin
      check_resp($sformatf("bresp for address %h", addr), rsp.bresp, exp_resp);
    end
    @(posedge clk);
    req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(posedge clk);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    req.rready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!rsp.arready && n < 64) begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    req.arvalid <= 1'b0;
    @(negedge clk);
    while (!rsp.rvalid && n < 64) begin
      @(negedge clk);
      n++;
    end
    if (n >= 64) begin
      err_cnt++;
      $display("timeout: the read from address %h got no response", addr);
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk);
    req.rready <= 1'b0;
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check_word($sformatf("rdata for address %h", addr), data, exp_data);
    check_resp($sformatf("rresp for address %h", addr), resp, exp_resp);
  endtask

  task automatic wait_frames(input int n);
    int target;
    int t;
    target = frames_seen + n;
    t = 0;
    while (frames_seen < target &&
           t < (n + 2) * gfx_pkg::H_WHOLE_LINE * gfx_pkg::V_WHOLE_FRAME) begin
      @(posedge clk);
      t++;
    end
    if (frames_seen < target) begin
      err_cnt++;
      $display("timeout: the display did not complete %0d frames", n);
    end
  endtask

  // width and period of a sync pulse, both in clocks, from one rising edge to the next
  task automatic measure_pulse(input bit use_v, input int limit, output int width,
                               output int period);
    int n;
    n = 0;
    width = 0;
    @(negedge clk);
    while (sync_level(use_v) && n < limit) begin
      @(negedge clk);
      n++;
    end
    while (!sync_level(use_v) && n < limit) begin
      @(negedge clk);
      n++;
    end
    while (sync_level(use_v) && n < limit) begin
      width++;
      @(negedge clk);
      n++;
    end
    period = width;
    while (!sync_level(use_v) && n < limit) begin
      period++;
      @(negedge clk);
      n++;
    end
    if (n >= limit) begin
      err_cnt++;
      $display("timeout: no complete %s pulse was seen", use_v ? "vsync" : "hsync");
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, err_cnt - err_before);
  endtask

  // frames are collected from de after each vsync so the first frame after enable is not armed
  always @(negedge clk) begin
    if (reset) begin
      armed      = 1'b0;
      vsync_prev = 1'b0;
      pix_idx    = 0;
      de_run     = 0;
      de_lines   = 0;
    end else begin
      if (vga.de) begin
        de_run++;
      end else begin
        check_rgb("vga.color in blanking", vga.color, '0);
        if (de_run != 0) begin
          check_count("de clocks per line", de_run, gfx_pkg::H_VISIBLE);
          de_lines++;
          de_run = 0;
        end
      end
      if (vga.vsync && !vsync_prev) begin
        check_count("de lines per frame", de_lines, gfx_pkg::V_VISIBLE);
        de_lines = 0;
      end
      vsync_prev = vga.vsync;
      if (vga.vsync) begin
        armed   = 1'b1;
        pix_idx = 0;
      end else if (vga.de && armed) begin
        if (skip_frames == 0) begin
          check_rgb($sformatf("pixel (%0d,%0d)", pix_idx % 16, pix_idx / 16), vga.color,
                    expected_pixel(exp_mode, exp_base, 4'(pix_idx % 16), 3'(pix_idx / 16)));
        end
        pix_idx++;
        if (pix_idx == gfx_pkg::H_VISIBLE * gfx_pkg::V_VISIBLE) begin
          armed = 1'b0;
          frames_seen++;
          if (skip_frames > 0) begin
            skip_frames--;
          end else begin
            frames_checked++;
          end
        end
      end
    end
  end

  initial begin
    int          mark;
    int          rnd;
    int          width;
    int          period;
    int          held;
    logic [31:0] st0;
    logic [31:0] st1;
    logic [1:0]  resp;

    req            = '0;
    reset          = 1'b1;
    err_cnt        = 0;
    chk_cnt        = 0;
    seed           = 32'hd7fa5344;
    frames_seen    = 0;
    frames_checked = 0;
    skip_frames    = 32'h7fff_ffff;
    exp_mode       = '0;
    exp_base       = '0;
    pat_model      = '0;

    mark = err_cnt;
    // reset spans five rising edges
    repeat (4) begin
      @(negedge clk);
      check_vga("vga during reset", vga, '0);
    end
    @(posedge clk);
    reset <= 1'b0;
    repeat (40) begin
      @(negedge clk);
      check_vga("vga before the first swap", vga, '0);
    end
    read_expect(gfx_pkg::REG_CTRL, 32'h0, gfx_pkg::RESP_OKAY);
    end_test("reset_state", mark);

    mark = err_cnt;
    axi_write(gfx_pkg::REG_PATTERN, 32'h0abc_0002, 4'hf, gfx_pkg::RESP_OKAY);
    pat_model = merge_strobes(pat_model, 32'h0abc_0002, 4'hf);
    read_expect(gfx_pkg::REG_PATTERN, pat_model, gfx_pkg::RESP_OKAY);
    axi_write(gfx_pkg::REG_PATTERN, 32'hff55_fffd, 4'b0100, gfx_pkg::RESP_OKAY);
    pat_model = merge_strobes(pat_model, 32'hff55_fffd, 4'b0100);
    read_expect(gfx_pkg::REG_PATTERN, pat_model, gfx_pkg::RESP_OKAY);
    axi_write(gfx_pkg::REG_PATTERN, 32'h0366_0001, 4'b1000, gfx_pkg::RESP_OKAY);
    pat_model = merge_strobes(pat_model, 32'h0366_0001, 4'b1000);
    read_expect(gfx_pkg::REG_PATTERN, pat_model, gfx_pkg::RESP_OKAY);
    axi_write(gfx_pkg::REG_STATUS, 32'h1234_5678, 4'hf, gfx_pkg::RESP_SLVERR);
    read_expect(gfx_pkg::REG_STATUS, 32'h0, gfx_pkg::RESP_OKAY);
    axi_write(4'hc, 32'hffff_ffff, 4'hf, gfx_pkg::RESP_SLVERR);
    read_expect(gfx_pkg::REG_PATTERN, pat_model, gfx_pkg::RESP_OKAY);
    read_expect(gfx_pkg::REG_CTRL, 32'h0, gfx_pkg::RESP_OKAY);
    read_expect(4'hc, 32'h0, gfx_pkg::RESP_SLVERR);
    end_test("register_access", mark);

    mark = err_cnt;
    axi_write(gfx_pkg::REG_CTRL, 32'h1, 4'hf, gfx_pkg::RESP_OKAY);
    wait_frames(1);
    repeat (3) begin
      measure_pulse(1'b0, 3 * gfx_pkg::H_WHOLE_LINE, width, period);
      check_count("hsync width", width, gfx_pkg::H_SYNC_PULSE);
      check_count("hsync period", period, gfx_pkg::H_WHOLE_LINE);
    end
    repeat (2) begin
      measure_pulse(1'b1, 3 * gfx_pkg::H_WHOLE_LINE * gfx_pkg::V_WHOLE_FRAME, width, period);
      check_count("vsync width", width, gfx_pkg::V_SYNC_PULSE * gfx_pkg::H_WHOLE_LINE);
      check_count("vsync period", period, gfx_pkg::V_WHOLE_FRAME * gfx_pkg::H_WHOLE_LINE);
    end
    end_test("sync_timing", mark);

    mark = err_cnt;
    for (int m = 0; m < 4; m++) begin
      rnd = $random(seed);
      axi_write(gfx_pkg::REG_PATTERN, {4'b0, rnd[11:0], 14'b0, 2'(m)}, 4'hf,
                gfx_pkg::RESP_OKAY);
      // frames already rendered with the old settings are still in the pipeline
      exp_mode       = 2'(m);
      exp_base       = rnd[11:0];
      skip_frames    = 3;
      frames_checked = 0;
      wait_frames(5);
      check_count($sformatf("frames compared in mode %0d", m), frames_checked, 2);
    end
    end_test("pixel_content", mark);

    mark = err_cnt;
    axi_read(gfx_pkg::REG_STATUS, st0, resp);
    check_resp("rresp for status", resp, gfx_pkg::RESP_OKAY);
    repeat (3) begin
      wait_frames(1);
      axi_read(gfx_pkg::REG_STATUS, st1, resp);
      check_word("status after one frame", st1, {st0[31:16] + 16'd1, 15'b0, !st0[0]});
      st0 = st1;
    end
    axi_write(gfx_pkg::REG_CTRL, 32'h0, 4'hf, gfx_pkg::RESP_OKAY);
    read_expect(gfx_pkg::REG_CTRL, 32'h0, gfx_pkg::RESP_OKAY);
    wait_frames(2);
    axi_read(gfx_pkg::REG_STATUS, st0, resp);
    held = frames_checked;
    wait_frames(3);
    axi_read(gfx_pkg::REG_STATUS, st1, resp);
    check_word("status after run cleared", st1, st0);
    check_count("frames compared while stopped", frames_checked - held, 3);
    end_test("swap_and_run", mark);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/gfx_pkg.sv
logic/gfx_regs.sv
logic/gfx_pattern.sv
logic/fb_dbuf.sv
logic/vga_scan.sv
logic/gfx_demo_dbuf.sv
verification/gfx_demo_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module gfx_demo_tb -o gfx_demo_sim
./obj_dir/gfx_demo_sim > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
